// ==== hw/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    // BTB index from pc[6:2] and tag from pc[31:7]
    localparam int BTB_IDX_W = 5;
    localparam int BTB_TAG_W = 32 - BTB_IDX_W - 2;
    localparam int BTB_ENTRIES = 1 << BTB_IDX_W;

    // Global history and the tables it indexes
    localparam int GHR_W = 12;
    localparam int PHT_IDX_W = 10;
    localparam int PHT_ENTRIES = 1 << PHT_IDX_W;

    // Local history table indexed by pc[9:2]
    // Each entry also holds LHT_IDX_W bits of history
    localparam int LHT_IDX_W = 8;
    localparam int LHT_ENTRIES = 1 << LHT_IDX_W;

    localparam logic [1:0] CTR_INIT = 2'b01; // Weakly not taken

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // One word in B-type or J-type layout
    // jalr's I-type immediate is imm12, imm10_5 and rs2 of the B view
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } rv_instr_u;

endpackage

`default_nettype wire

// ==== hw/ctrl_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module ctrl_decode
    import rv_isa_pkg::*;
(
    input  rv_instr_u   id_instr,
    output logic        is_branch,
    output logic        is_jal,
    output logic        is_jalr,
    output logic [2:0]  funct3,
    output logic [31:0] imm
);

    assign funct3 = id_instr.b_fmt.funct3;

    always_comb begin
        is_branch = 1'b0;
        is_jal = 1'b0;
        is_jalr = 1'b0;
        imm = '0;
        // Opcode sits in the same bits for both views
        case (id_instr.b_fmt.opcode)
            OP_BRANCH: begin
                is_branch = 1'b1;
                imm = {{19{id_instr.b_fmt.imm12}}, id_instr.b_fmt.imm12,
                       id_instr.b_fmt.imm11, id_instr.b_fmt.imm10_5,
                       id_instr.b_fmt.imm4_1, 1'b0};
            end
            OP_JAL: begin
                is_jal = 1'b1;
                imm = {{11{id_instr.j_fmt.imm20}}, id_instr.j_fmt.imm20,
                       id_instr.j_fmt.imm19_12, id_instr.j_fmt.imm11,
                       id_instr.j_fmt.imm10_1, 1'b0};
            end
            OP_JALR: begin
                is_jalr = 1'b1;
                // I-type imm[11:0] = instr[31:20]
                imm = {{20{id_instr.b_fmt.imm12}}, id_instr.b_fmt.imm12,
                       id_instr.b_fmt.imm10_5, id_instr.b_fmt.rs2};
            end
            default: ; // Not a control instruction
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/branch_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_execute
    import rv_isa_pkg::*;
(
    input  logic [31:0] ex_pc,
    input  logic [31:0] ex_rs1,
    input  logic [31:0] ex_rs2,
    input  logic [31:0] ex_imm,
    input  logic [2:0]  ex_funct3,
    input  logic        ex_is_branch,
    input  logic        ex_is_jal,
    input  logic        ex_is_jalr,
    output logic        taken,
    output logic        is_ctrl,
    output logic [31:0] target
);

    logic        cond;
    logic [31:0] jalr_sum;

    always_comb begin
        case (ex_funct3)
            F3_BEQ:  cond = (ex_rs1 == ex_rs2);
            F3_BNE:  cond = (ex_rs1 != ex_rs2);
            F3_BLT:  cond = ($signed(ex_rs1) < $signed(ex_rs2));
            F3_BGE:  cond = ($signed(ex_rs1) >= $signed(ex_rs2));
            F3_BLTU: cond = (ex_rs1 < ex_rs2);
            F3_BGEU: cond = (ex_rs1 >= ex_rs2);
            default: cond = 1'b0; // Reserved encodings never branch
        endcase
    end

    assign jalr_sum = ex_rs1 + ex_imm;

    assign is_ctrl = ex_is_branch | ex_is_jal | ex_is_jalr;
    assign taken = (ex_is_branch & cond) | ex_is_jal | ex_is_jalr;

    // BTB stores the branch target even when not taken
    assign target = ex_is_jalr ? {jalr_sum[31:1], 1'b0} : ex_pc + ex_imm;

endmodule

`default_nettype wire

// ==== hw/tournament_predictor.sv ====
`timescale 1ns/100ps
`default_nettype none

module tournament_predictor
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] fetch_pc,
    output logic [31:0] pred_pc,
    input  logic [31:0] ex_pc,
    input  logic [31:0] target,
    input  logic        is_ctrl,
    input  logic        ex_is_branch,
    input  logic        taken
);

    logic [GHR_W-1:0]     ghr;
    logic [LHT_IDX_W-1:0] lht [LHT_ENTRIES];
    logic [1:0]           local_ctr [LHT_ENTRIES];
    logic [1:0]           global_ctr [PHT_ENTRIES];
    logic [1:0]           choice_ctr [PHT_ENTRIES];

    logic                 btb_valid [BTB_ENTRIES];
    logic                 btb_is_branch [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0] btb_tag [BTB_ENTRIES];
    logic [31:0]          btb_target [BTB_ENTRIES];

    logic [PHT_IDX_W-1:0] g_idx;
    logic [BTB_IDX_W-1:0] f_btb_idx;
    logic [BTB_TAG_W-1:0] f_tag;
    logic [LHT_IDX_W-1:0] f_lhist;
    logic                 f_dir;
    logic                 f_hit;
    logic [BTB_IDX_W-1:0] e_btb_idx;
    logic [LHT_IDX_W-1:0] e_lht_idx;
    logic [LHT_IDX_W-1:0] e_lhist;
    logic                 e_local;
    logic                 e_global;

    function automatic logic [1:0] sat_update(input logic [1:0] ctr, input logic up);
        logic [1:0] next;
        next = ctr;
        if (up && ctr != 2'b11)
            next = ctr + 2'd1;
        else if (!up && ctr != 2'b00)
            next = ctr - 2'd1;
        return next;
    endfunction

    // Upper history bits folded into the table index
    assign g_idx = ghr[PHT_IDX_W-1:0] ^ PHT_IDX_W'(ghr[GHR_W-1:PHT_IDX_W]);

    // Fetch side
    assign f_btb_idx = fetch_pc[BTB_IDX_W+1:2];
    assign f_tag = fetch_pc[31:BTB_IDX_W+2];
    assign f_lhist = lht[fetch_pc[LHT_IDX_W+1:2]];
    assign f_dir = choice_ctr[g_idx][1] ? global_ctr[g_idx][1] : local_ctr[f_lhist][1];
    assign f_hit = btb_valid[f_btb_idx] && (btb_tag[f_btb_idx] == f_tag);

    always_comb begin
        pred_pc = fetch_pc + 32'd4;
        if (f_hit && (!btb_is_branch[f_btb_idx] || f_dir))
            pred_pc = btb_target[f_btb_idx];
    end

    // EX side components recomputed from the current tables
    assign e_btb_idx = ex_pc[BTB_IDX_W+1:2];
    assign e_lht_idx = ex_pc[LHT_IDX_W+1:2];
    assign e_lhist = lht[e_lht_idx];
    assign e_local = local_ctr[e_lhist][1];
    assign e_global = global_ctr[g_idx][1];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < LHT_ENTRIES; i++) begin
                lht[i] <= '0;
                local_ctr[i] <= CTR_INIT;
            end
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                global_ctr[i] <= CTR_INIT;
                choice_ctr[i] <= CTR_INIT;
            end
            for (int i = 0; i < BTB_ENTRIES; i++)
                btb_valid[i] <= 1'b0;
        end else if (is_ctrl) begin
            btb_valid[e_btb_idx] <= 1'b1;
            ghr <= {ghr[GHR_W-2:0], taken};
            lht[e_lht_idx] <= {e_lhist[LHT_IDX_W-2:0], taken};
            local_ctr[e_lhist] <= sat_update(local_ctr[e_lhist], taken);
            global_ctr[g_idx] <= sat_update(global_ctr[g_idx], taken);
            // Only a disagreement says anything about the chooser
            if (e_local != e_global)
                choice_ctr[g_idx] <= sat_update(choice_ctr[g_idx], e_global == taken);
        end
    end

    always_ff @(posedge clk) begin
        if (is_ctrl) begin
            btb_tag[e_btb_idx] <= ex_pc[31:BTB_IDX_W+2];
            btb_target[e_btb_idx] <= target;
            btb_is_branch[e_btb_idx] <= ex_is_branch; // jal/jalr always redirect
        end
    end

endmodule

`default_nettype wire

// ==== hw/pc_redirect.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_redirect
    import bp_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic        is_branch,
    input  logic        is_jal,
    input  logic        is_jalr,
    input  logic [2:0]  funct3,
    input  logic [31:0] imm,
    input  logic [31:0] pred_pc,
    input  logic [31:0] target,
    input  logic        taken,
    input  logic        is_ctrl,
    output logic [31:0] fetch_pc,
    output logic [31:0] id_instr,
    output logic [31:0] id_rs1,
    output logic [31:0] id_rs2,
    output logic [31:0] ex_pc,
    output logic [31:0] ex_rs1,
    output logic [31:0] ex_rs2,
    output logic [31:0] ex_imm,
    output logic [2:0]  ex_funct3,
    output logic        ex_is_branch,
    output logic        ex_is_jal,
    output logic        ex_is_jalr,
    output logic        flush
);

    logic [31:0] id_pc;
    logic [31:0] actual_pc;

    // Where the EX instruction really goes next
    assign actual_pc = taken ? target : ex_pc + 32'd4;

    // ID holds what was fetched behind EX; a wrong guess shows up here
    assign flush = is_ctrl && (actual_pc != id_pc);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
            id_instr <= '0;
            ex_is_branch <= 1'b0;
            ex_is_jal <= 1'b0;
            ex_is_jalr <= 1'b0;
        end else if (flush) begin
            fetch_pc <= actual_pc;
            id_instr <= '0; // Opcode 0 decodes to no flags
            ex_is_branch <= 1'b0;
            ex_is_jal <= 1'b0;
            ex_is_jalr <= 1'b0;
        end else begin
            fetch_pc <= pred_pc;
            id_instr <= instr;
            ex_is_branch <= is_branch;
            ex_is_jal <= is_jal;
            ex_is_jalr <= is_jalr;
        end
    end

    // Data half of both stage registers
    always_ff @(posedge clk) begin
        id_pc <= fetch_pc;
        id_rs1 <= rs1_data;
        id_rs2 <= rs2_data;
        ex_pc <= id_pc;
        ex_rs1 <= id_rs1;
        ex_rs2 <= id_rs2;
        ex_imm <= imm;
        ex_funct3 <= funct3;
    end

endmodule

`default_nettype wire

// ==== hw/branch_unit_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_unit_top (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic [31:0] fetch_pc,
    output logic        flush
);

    logic [31:0] id_instr, id_rs1, id_rs2;
    logic [31:0] ex_pc, ex_rs1, ex_rs2, ex_imm;
    logic [2:0]  ex_funct3;
    logic        ex_is_branch, ex_is_jal, ex_is_jalr;
    logic        is_branch, is_jal, is_jalr;
    logic [2:0]  funct3;
    logic [31:0] imm;
    logic        taken, is_ctrl;
    logic [31:0] target;
    logic [31:0] pred_pc;

    pc_redirect u_pc_redirect (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .is_branch    (is_branch),
        .is_jal       (is_jal),
        .is_jalr      (is_jalr),
        .funct3       (funct3),
        .imm          (imm),
        .pred_pc      (pred_pc),
        .target       (target),
        .taken        (taken),
        .is_ctrl      (is_ctrl),
        .fetch_pc     (fetch_pc),
        .id_instr     (id_instr),
        .id_rs1       (id_rs1),
        .id_rs2       (id_rs2),
        .ex_pc        (ex_pc),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_imm       (ex_imm),
        .ex_funct3    (ex_funct3),
        .ex_is_branch (ex_is_branch),
        .ex_is_jal    (ex_is_jal),
        .ex_is_jalr   (ex_is_jalr),
        .flush        (flush)
    );

    ctrl_decode u_ctrl_decode (
        .id_instr  (id_instr),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .is_jalr   (is_jalr),
        .funct3    (funct3),
        .imm       (imm)
    );

    branch_execute u_branch_execute (
        .ex_pc        (ex_pc),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_imm       (ex_imm),
        .ex_funct3    (ex_funct3),
        .ex_is_branch (ex_is_branch),
        .ex_is_jal    (ex_is_jal),
        .ex_is_jalr   (ex_is_jalr),
        .taken        (taken),
        .is_ctrl      (is_ctrl),
        .target       (target)
    );

    // Predicts from fetch_pc, trained from EX
    tournament_predictor u_tournament_predictor (
        .clk          (clk),
        .reset        (reset),
        .fetch_pc     (fetch_pc),
        .pred_pc      (pred_pc),
        .ex_pc        (ex_pc),
        .target       (target),
        .is_ctrl      (is_ctrl),
        .ex_is_branch (ex_is_branch),
        .taken        (taken)
    );

endmodule

`default_nettype wire

// ==== tests/tb_branch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_branch_unit
    import bp_pkg::*, rv_isa_pkg::*;
();

    localparam int MAX_CYCLES = 400;
    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam logic [31:0] JALR_BASE = 32'h0000_003c; // Plus 5 gives an odd sum

    logic        clk;
    logic        reset;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] fetch_pc;
    logic        flush;

    logic [31:0] prog [24];
    logic        seen [24];    // Jumps already resolved once
    logic [31:0] lfsr;
    logic [31:0] loop_cnt;
    logic [31:0] passes_left;
    logic [31:0] arch_next;    // Correct-path successor of the last fetch
    logic [31:0] exp_fetch;
    logic        fetch_chk;
    logic        exp_flush;
    logic        mis_d;
    logic        last_ctrl;
    logic        last_jump;
    logic        last_seen;
    int          squash;
    int          cycles;
    int          retire_at;

    branch_unit_top u_branch_unit_top (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fetch_pc (fetch_pc),
        .flush    (flush)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, OP_JAL};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rs1, input logic [11:0] off);
        return {off, rs1, 3'b000, 5'd0, OP_JALR};
    endfunction

    function automatic logic [31:0] branch_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] jump_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (addr < 32'd96)
            return prog[addr[6:2]];
        return {addr[24:0] ^ addr[31:7], 7'b0010011}; // Filler addi that is never a control word
    endfunction

    // Fibonacci LFSR with taps at x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("Mismatch %s: expected %h, got %h", name, exp_val, act_val);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s check failed", name);
    endtask

    // Runs once per falling edge for the address fetched this cycle
    task automatic step_model();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] succ;
        logic        is_jump;
        logic        on_path;
        exp_flush = mis_d; // EX holds the fetch from two cycles back
        exp_fetch = arch_next;
        mis_d = 1'b0;
        on_path = 1'b0;
        if (squash > 0) begin
            squash--;
        end else if (last_ctrl && !last_seen && (last_jump || fetch_pc != arch_next)) begin
            mis_d = 1'b1; // Wrong path now and next cycle
            squash = 1;
            last_ctrl = 1'b0;
        end else begin
            on_path = 1'b1;
        end
        fetch_chk = on_path;
        w = word_at(fetch_pc);
        a = '0;
        b = '0;
        if (on_path) begin
            case (fetch_pc)
                32'h18: loop_cnt = 32'd6;
                32'h20: loop_cnt = loop_cnt - 32'd1;
                32'h24: a = loop_cnt;
                32'h2c: a = JALR_BASE;
                32'h40, 32'h48: begin
                    a = rand_word();
                    b = rand_word();
                end
                32'h54: begin
                    a = passes_left;
                    passes_left = passes_left - 32'd1;
                end
                32'h58: retire_at = cycles + 3; // Last word reaches EX two cycles on
                default: ;
            endcase
            succ = fetch_pc + 32'd4;
            is_jump = (w[6:0] == OP_JAL) || (w[6:0] == OP_JALR);
            if (w[6:0] == OP_BRANCH && branch_taken(w[14:12], a, b))
                succ = fetch_pc + branch_offset(w);
            else if (w[6:0] == OP_JAL)
                succ = fetch_pc + jump_offset(w);
            else if (w[6:0] == OP_JALR)
                succ = (a + {{20{w[31]}}, w[31:20]}) & ~32'd1;
            last_jump = is_jump; // A new jump cannot hit in the BTB
            last_ctrl = is_jump || (w[6:0] == OP_BRANCH);
            last_seen = 1'b0;
            if (is_jump && fetch_pc < 32'd96) begin
                last_seen = seen[fetch_pc[6:2]]; // Known jump must hit in the BTB
                seen[fetch_pc[6:2]] = 1'b1;
            end
            arch_next = succ;
        end
        instr = w;
        rs1_data = a;
        rs2_data = b;
    endtask

    assert property (@(posedge clk) $fell(reset) |-> fetch_pc == RESET_PC)
        else report_mismatch("fetch_pc", RESET_PC, $sampled(fetch_pc));

    assert property (@(posedge clk) disable iff (reset) fetch_chk |-> fetch_pc == exp_fetch)
        else report_mismatch("fetch_pc", exp_fetch, $sampled(fetch_pc));

    // Only a mispredicted control instruction in EX may flush
    assert property (@(posedge clk) disable iff (reset) flush == exp_flush)
        else report_mismatch("flush", {31'd0, exp_flush}, {31'd0, $sampled(flush)});

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr = NOP;
        rs1_data = '0;
        rs2_data = '0;
        lfsr = 32'h35dc_e128;
        loop_cnt = '0;
        passes_left = 32'd1;
        arch_next = RESET_PC;
        exp_fetch = RESET_PC;
        fetch_chk = 1'b0;
        exp_flush = 1'b0;
        mis_d = 1'b0;
        last_ctrl = 1'b0;
        last_jump = 1'b0;
        last_seen = 1'b0;
        squash = 0;
        cycles = 0;
        retire_at = -1;
        foreach (prog[i]) begin
            prog[i] = NOP;
            seen[i] = 1'b0;
        end
        prog[3] = jal_word(21'd12);                              // 0x0c to 0x18
        prog[9] = branch_word(F3_BNE, 5'd5, 5'd0, -13'sd8);      // Loop back to 0x1c
        prog[11] = jalr_word(5'd6, 12'd5);
        prog[16] = branch_word(F3_BLTU, 5'd7, 5'd8, 13'd8);
        prog[18] = branch_word(F3_BGE, 5'd9, 5'd10, 13'd8);
        prog[21] = branch_word(F3_BNE, 5'd11, 5'd0, -13'sd84);   // Second pass from 0x00
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (cycles != retire_at && cycles < MAX_CYCLES) begin
            step_model();
            @(negedge clk);
            cycles++;
        end
        if (cycles == retire_at) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("Final instruction did not retire within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

// ==== branch_unit.f ====
hw/bp_pkg.sv
hw/rv_isa_pkg.sv
hw/ctrl_decode.sv
hw/branch_execute.sv
hw/tournament_predictor.sv
hw/pc_redirect.sv
hw/branch_unit_top.sv
tests/tb_branch_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_branch_unit \
    -f branch_unit.f

./obj_dir/Vtb_branch_unit
